// File: verilog.f
ex_types_pkg.sv
alu_op_pkg.sv
div_if.sv
alu_unit.sv
div_ctrl.sv
div_counter.sv
div_datapath.sv
ex_output_stage.sv
ex_top.sv
tb_ex_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ex_top -f verilog.f -o sim_ex_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_ex_top
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

// File: tb_ex_top.sv
module tb_ex_top;
	timeunit 1ns;
	timeprecision 1ps;
	import ex_types_pkg::*;
	import alu_op_pkg::*;

	localparam int n_rand = 150;
	localparam int n_ops = 53 + n_rand; // directed ops plus random ones
	localparam int watchdog_cycles = n_ops * 80 + 200;
	localparam logic [4:0] word_ops [5] = '{5'd1, 5'd3, 5'd5, 5'd7, 5'd18};

	logic clk, reset, up_valid, branch, reg_w_en, down_ready;
	alu_op_e op;
	word_t src_a, src_b, pc;
	b_imm_t b_imm;
	reg_addr_t rd, wb_rd;
	logic up_ready, down_valid, wb_reg_w_en, branch_taken;
	word_t ex_result, branch_target;

	logic [31:0] lfsr = 32'd95816;
	logic bp_mode;
	word_t exp_q[$];
	bit word_q[$];
	logic [5:0] wb_q[$]; // rd and reg_w_en of each pending result
	word_t exp_head, prev_result, exp_target;
	logic [5:0] exp_wb;
	logic [5:0] prev_wb;
	int exp_count, div_wait, min_wait;
	logic exp_word, took, prev_stall, exp_taken;
	logic [4:0] code;
	logic div_code, word_code;

	ex_top uut (.*);

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t rand_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic pick_ready();
		return bp_mode ? (rand_bits(2) != '0) : 1'b1; // high 3 of 4 under back-pressure
	endfunction

	function automatic word_t sext32(logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	function automatic word_t alu_model(logic [4:0] c, word_t a, word_t b);
		logic [31:0] w;
		w = '0;
		case (c)
			5'd0: return a + b;
			5'd1: w = a[31:0] + b[31:0];
			5'd2: return a << b[5:0];
			5'd3: w = a[31:0] << b[4:0];
			5'd4: return $signed(a) >>> b[5:0];
			5'd5: w = $signed(a[31:0]) >>> b[4:0];
			5'd6: return a >> b[5:0];
			5'd7: w = a[31:0] >> b[4:0];
			5'd8: return a & b;
			5'd9: return a | b;
			5'd10: return a ^ b;
			5'd11: return word_t'($signed(a) < $signed(b));
			5'd12: return word_t'(a < b);
			5'd13: return word_t'(a == b);
			5'd14: return word_t'(a != b);
			5'd15: return word_t'($signed(a) >= $signed(b));
			5'd16: return word_t'(a >= b);
			5'd17: return a - b;
			5'd18: w = a[31:0] - b[31:0];
			default: return '0;
		endcase
		return sext32(w);
	endfunction

	// riscv div/rem rules, word forms done on extended operands
	function automatic word_t div_model(logic [4:0] c, word_t a, word_t b);
		logic sgn, rem, wrd;
		word_t x, y, res;
		sgn = c inside {5'd23, 5'd25, 5'd27, 5'd30};
		rem = c inside {5'd27, 5'd28, 5'd29, 5'd30};
		wrd = c inside {5'd25, 5'd26, 5'd29, 5'd30};
		x = wrd ? (sgn ? sext32(a[31:0]) : {32'b0, a[31:0]}) : a;
		y = wrd ? (sgn ? sext32(b[31:0]) : {32'b0, b[31:0]}) : b;
		if (y == '0)
			res = rem ? x : '1;
		else if (sgn && x == {1'b1, 63'b0} && y == '1)
			res = rem ? '0 : x; // overflow
		else if (sgn)
			res = rem ? $signed(x) % $signed(y) : $signed(x) / $signed(y);
		else
			res = rem ? x % y : x / y;
		return wrd ? sext32(res[31:0]) : res;
	endfunction

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(string name, word_t got, word_t exp);
		stop_on_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	// present one op and hold it until accepted
	task automatic send(logic [4:0] c, word_t a, word_t b);
		up_valid = 1'b1;
		op = alu_op_e'(c);
		src_a = a;
		src_b = b;
		pc = rand_bits(64);
		branch = 1'(rand_bits(1));
		b_imm = b_imm_t'(rand_bits(12));
		rd = reg_addr_t'(rand_bits(5));
		reg_w_en = 1'(rand_bits(1));
		down_ready = pick_ready();
		do begin
			@(negedge clk);
			down_ready = pick_ready();
		end while (!took);
	endtask

	assign code = op;
	assign div_code = (code >= 5'd23) && (code <= 5'd30);
	assign word_code = code inside {5'd1, 5'd3, 5'd5, 5'd7, 5'd18, 5'd25, 5'd26, 5'd29, 5'd30};
	assign min_wait = word_code ? 33 : 65; // load cycle plus iterations
	assign exp_taken = branch && (alu_model(code, src_a, src_b) != '0);
	assign exp_target = pc + ({{52{b_imm[12]}}, b_imm} << 1);

	always @(posedge clk) begin
		if (reset) begin
			exp_q.delete();
			word_q.delete();
			wb_q.delete();
			div_wait <= 0;
		end else begin
			if (down_valid && down_ready && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				void'(word_q.pop_front());
				void'(wb_q.pop_front());
			end
			if (up_valid && up_ready) begin
				exp_q.push_back(div_code ? div_model(code, src_a, src_b)
					: alu_model(code, src_a, src_b));
				word_q.push_back(word_code);
				wb_q.push_back({rd, reg_w_en});
				div_wait <= 0;
			end else if (up_valid && div_code) begin
				div_wait <= div_wait + 1;
			end
		end
		exp_count <= exp_q.size();
		exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
		exp_word <= (word_q.size() > 0) ? word_q[0] : 1'b0;
		exp_wb <= (wb_q.size() > 0) ? wb_q[0] : '0;
		took <= up_valid && up_ready;
		prev_stall <= down_valid && !down_ready;
		prev_result <= ex_result;
		prev_wb <= {wb_rd, wb_reg_w_en};
	end

	no_extra_output: assert property (@(posedge clk) disable iff (reset)
		down_valid && down_ready |-> exp_count > 0)
		else stop_on_error("output transfer with no result pending");
	result_matches: assert property (@(posedge clk) disable iff (reset)
		down_valid && down_ready && exp_count > 0 |-> ex_result == exp_head)
		else report_mismatch("ex_result", $sampled(ex_result), $sampled(exp_head));
	rd_matches: assert property (@(posedge clk) disable iff (reset)
		down_valid && down_ready && exp_count > 0 |-> wb_rd == exp_wb[5:1])
		else report_mismatch("wb_rd", 64'($sampled(wb_rd)), 64'($sampled(exp_wb[5:1])));
	w_en_matches: assert property (@(posedge clk) disable iff (reset)
		down_valid && down_ready && exp_count > 0 |-> wb_reg_w_en == exp_wb[0])
		else report_mismatch("wb_reg_w_en", 64'($sampled(wb_reg_w_en)),
			64'($sampled(exp_wb[0])));
	word_sign_ext: assert property (@(posedge clk) disable iff (reset)
		down_valid && down_ready && exp_count > 0 && exp_word
			|-> ex_result[63:32] == {32{ex_result[31]}})
		else report_mismatch("ex_result", $sampled(ex_result), sext32($sampled(ex_result[31:0])));
	stall_holds: assert property (@(posedge clk) disable iff (reset)
		prev_stall |-> down_valid && ex_result == prev_result)
		else report_mismatch("ex_result", $sampled(ex_result), $sampled(prev_result));
	wb_stall_holds: assert property (@(posedge clk) disable iff (reset)
		prev_stall |-> {wb_rd, wb_reg_w_en} == prev_wb)
		else report_mismatch("{wb_rd, wb_reg_w_en}", 64'($sampled({wb_rd, wb_reg_w_en})),
			64'($sampled(prev_wb)));
	div_latency: assert property (@(posedge clk) disable iff (reset)
		up_valid && up_ready && div_code |-> div_wait >= min_wait)
		else report_mismatch("up_ready low cycles", 64'($sampled(div_wait)), 64'(min_wait));
	ready_follows: assert property (@(posedge clk) disable iff (reset)
		!(up_valid && div_code) |-> up_ready == down_ready)
		else report_mismatch("up_ready", 64'($sampled(up_ready)), 64'($sampled(down_ready)));
	taken_matches: assert property (@(posedge clk) disable iff (reset)
		up_valid && !div_code |-> branch_taken == exp_taken)
		else report_mismatch("branch_taken", 64'($sampled(branch_taken)), 64'($sampled(exp_taken)));
	target_matches: assert property (@(posedge clk) disable iff (reset)
		up_valid && !div_code |-> branch_target == exp_target)
		else report_mismatch("branch_target", $sampled(branch_target), $sampled(exp_target));
	reset_clears: assert property (@(posedge clk) $fell(reset) |-> !down_valid)
		else report_mismatch("down_valid", 64'($sampled(down_valid)), 64'd0);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		stop_on_error($sformatf("timeout, run still busy after %0d cycles", watchdog_cycles));
	end

	initial begin
		word_t a;
		logic [4:0] c;
		reset = 1'b1;
		up_valid = 1'b0;
		op = op_add;
		src_a = '0;
		src_b = '0;
		pc = '0;
		branch = 1'b0;
		b_imm = '0;
		rd = '0;
		reg_w_en = 1'b0;
		down_ready = 1'b1;
		bp_mode = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (4) begin
			@(negedge clk);
			down_ready = 1'(rand_bits(1));
		end
		for (int i = 0; i < 32; i++) begin
			if (i < 23 || i == 31)
				send(5'(i), rand_bits(64), rand_bits(64)); // includes unused codes
		end
		foreach (word_ops[i])
			send(word_ops[i], rand_bits(64) | 64'h8000_0000, rand_bits(4));
		for (int i = 23; i <= 30; i++) begin
			send(5'(i), rand_bits(64), rand_bits(64) >> rand_bits(6));
			send(5'(i), rand_bits(64), '0);
			a = (i == 25 || i == 26 || i >= 29) ? 64'h8000_0000 : {1'b1, 63'b0};
			send(5'(i), a, '1); // most negative over -1
		end
		bp_mode = 1'b1;
		repeat (n_rand) begin
			c = 5'(rand_bits(5));
			send(c, rand_bits(64), rand_bits(64) >> rand_bits(6));
		end
		up_valid = 1'b0;
		down_ready = 1'b1;
		repeat (4) @(negedge clk);
		if (exp_q.size() != 0) begin
			stop_on_error($sformatf("%0d results never reached the output", exp_q.size()));
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// File: ex_top.sv
module ex_top (
	input  logic clk,
	input  logic reset,
	input  logic up_valid,
	input  alu_op_pkg::alu_op_e op,
	input  ex_types_pkg::word_t src_a,
	input  ex_types_pkg::word_t src_b,
	input  ex_types_pkg::word_t pc,
	input  logic branch,
	input  ex_types_pkg::b_imm_t b_imm,
	input  ex_types_pkg::reg_addr_t rd,
	input  logic reg_w_en,
	input  logic down_ready,
	output logic up_ready,
	output logic down_valid,
	output ex_types_pkg::reg_addr_t wb_rd,
	output logic wb_reg_w_en,
	output ex_types_pkg::word_t ex_result,
	output logic branch_taken,
	output ex_types_pkg::word_t branch_target
);
	import ex_types_pkg::*;

	word_t alu_result;
	word_t div_result;
	logic accept;
	logic use_div;

	div_if div_bus ();

	alu_unit u_alu (
		.op         (op),
		.src_a      (src_a),
		.src_b      (src_b),
		.alu_result (alu_result)
	);

	div_ctrl u_div_ctrl (
		.clk        (clk),
		.reset      (reset),
		.op         (op),
		.up_valid   (up_valid),
		.down_ready (down_ready),
		.up_ready   (up_ready),
		.accept     (accept),
		.use_div    (use_div),
		.div        (div_bus.ctrl)
	);

	div_counter u_div_counter (
		.clk   (clk),
		.reset (reset),
		.div   (div_bus.counter)
	);

	div_datapath u_div_datapath (
		.clk        (clk),
		.src_a      (src_a),
		.src_b      (src_b),
		.div_result (div_result),
		.div        (div_bus.datapath)
	);

	ex_output_stage u_out (
		.clk           (clk),
		.reset         (reset),
		.accept        (accept),
		.use_div       (use_div),
		.down_ready    (down_ready),
		.branch        (branch),
		.reg_w_en      (reg_w_en),
		.alu_result    (alu_result),
		.div_result    (div_result),
		.pc            (pc),
		.b_imm         (b_imm),
		.rd            (rd),
		.down_valid    (down_valid),
		.wb_rd         (wb_rd),
		.wb_reg_w_en   (wb_reg_w_en),
		.ex_result     (ex_result),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

endmodule

// File: ex_output_stage.sv
module ex_output_stage (
	input  logic clk,
	input  logic reset,
	input  logic accept,
	input  logic use_div,
	input  logic down_ready,
	input  logic branch,
	input  logic reg_w_en,
	input  ex_types_pkg::word_t alu_result,
	input  ex_types_pkg::word_t div_result,
	input  ex_types_pkg::word_t pc,
	input  ex_types_pkg::b_imm_t b_imm,
	input  ex_types_pkg::reg_addr_t rd,
	output logic down_valid,
	output ex_types_pkg::reg_addr_t wb_rd,
	output logic wb_reg_w_en,
	output ex_types_pkg::word_t ex_result,
	output logic branch_taken,
	output ex_types_pkg::word_t branch_target
);
	import ex_types_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			down_valid <= 1'b0;
			wb_reg_w_en <= 1'b0;
		end else if (down_ready) begin
			down_valid <= accept;
			if (accept) begin
				wb_reg_w_en <= reg_w_en;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (down_ready && accept) begin
			ex_result <= use_div ? div_result : alu_result;
			wb_rd <= rd;
		end
	end

	assign branch_taken = branch && (alu_result != '0);
	assign branch_target = pc + {{(xlen-13){b_imm[12]}}, b_imm, 1'b0};

	// accepted item needs a free output register
	accept_needs_ready: assert property (@(posedge clk) disable iff (reset)
		accept |-> down_ready)
		else $error("item accepted while output stalled");

endmodule

// File: div_datapath.sv
module div_datapath (
	input  logic clk,
	input  ex_types_pkg::word_t src_a,
	input  ex_types_pkg::word_t src_b,
	output ex_types_pkg::word_t div_result,
	div_if.datapath div
);
	import ex_types_pkg::*;

	word_t a_ext;
	word_t b_ext;
	word_t a_mag;
	word_t b_mag;
	logic a_neg;
	logic b_neg;
	word_t dvd_q; // dividend shifts out, quotient shifts in
	word_t part_rem;
	word_t dsr;
	logic q_neg;
	logic r_neg;
	logic dsr_zero;
	logic [xlen:0] trial;
	word_t q_fix;
	word_t r_fix;
	word_t pick;

	function automatic word_t widen(half_t h, logic sgn);
		return {{hlen{sgn & h[hlen-1]}}, h};
	endfunction

	always_comb begin
		a_ext = div.is_word ? widen(src_a[hlen-1:0], div.is_signed) : src_a;
		b_ext = div.is_word ? widen(src_b[hlen-1:0], div.is_signed) : src_b;
		a_neg = div.is_signed & a_ext[xlen-1];
		b_neg = div.is_signed & b_ext[xlen-1];
		a_mag = a_neg ? -a_ext : a_ext;
		b_mag = b_neg ? -b_ext : b_ext;
	end

	assign trial = {part_rem, dvd_q[xlen-1]} - {1'b0, dsr};

	always_ff @(posedge clk) begin
		if (div.load) begin
			// word dividend goes to the top so 32 steps drain it
			dvd_q <= div.is_word ? {a_mag[hlen-1:0], {hlen{1'b0}}} : a_mag;
			part_rem <= '0;
			dsr <= b_mag;
			q_neg <= a_neg ^ b_neg;
			r_neg <= a_neg;
			dsr_zero <= (b_ext == '0);
		end else if (div.step) begin
			if (!trial[xlen]) begin
				part_rem <= trial[xlen-1:0];
			end else begin
				part_rem <= {part_rem[xlen-2:0], dvd_q[xlen-1]}; // restore
			end
			dvd_q <= {dvd_q[xlen-2:0], !trial[xlen]};
		end
	end

	always_comb begin
		q_fix = (q_neg && !dsr_zero) ? -dvd_q : dvd_q;
		r_fix = r_neg ? -part_rem : part_rem;
		pick = div.want_rem ? r_fix : q_fix;
		div_result = div.is_word ? widen(pick[hlen-1:0], 1'b1) : pick;
	end

endmodule

// File: div_counter.sv
module div_counter (
	input logic clk,
	input logic reset,
	div_if.counter div
);
	import ex_types_pkg::*;

	logic [6:0] count; // iterations left

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (div.load) begin
			count <= div.is_word ? 7'(hlen) : 7'(xlen);
		end else if (div.step) begin
			count <= count - 7'd1;
		end
	end

	assign div.last = (count == 7'd1);

	step_needs_count: assert property (@(posedge clk) disable iff (reset)
		div.step |-> count != 7'd0)
		else $error("div step with empty counter");

endmodule

// File: div_ctrl.sv
module div_ctrl (
	input  logic clk,
	input  logic reset,
	input  alu_op_pkg::alu_op_e op,
	input  logic up_valid,
	input  logic down_ready,
	output logic up_ready,
	output logic accept,
	output logic use_div,
	div_if.ctrl div
);
	import alu_op_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} state_e;

	state_e state;
	state_e state_next;

	// op decode, op is held while up_ready is low
	always_comb begin
		use_div = op_is_div(op);
		div.is_word = op inside {op_divw, op_divuw, op_remuw, op_remw};
		div.is_signed = op inside {op_div, op_divw, op_rem, op_remw};
		div.want_rem = op inside {op_rem, op_remu, op_remuw, op_remw};
	end

	assign div.load = (state == st_idle) && up_valid && use_div;
	assign div.step = (state == st_run);

	always_comb begin
		case (state)
			st_idle: up_ready = down_ready && !(up_valid && use_div);
			st_done: up_ready = down_ready;
			default: up_ready = 1'b0; // divider busy
		endcase
	end

	assign accept = up_valid && up_ready;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (div.load) state_next = st_run;
			st_run:  if (div.last) state_next = st_done;
			st_done: if (accept) state_next = st_idle;
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// mode flags follow op until the divide is accepted
	op_held: assert property (@(posedge clk) disable iff (reset)
		up_valid && !up_ready |=> up_valid && $stable(op))
		else $error("op changed before it was accepted");

	// counter ends the run after the full number of steps
	run_length: assert property (@(posedge clk) disable iff (reset)
		div.step && div.last |-> (div.is_word ? $past(div.load, 32) : $past(div.load, 64)))
		else $error("divider ran the wrong number of steps");

endmodule

// File: alu_unit.sv
module alu_unit (
	input  alu_op_pkg::alu_op_e op,
	input  ex_types_pkg::word_t src_a,
	input  ex_types_pkg::word_t src_b,
	output ex_types_pkg::word_t alu_result
);
	import ex_types_pkg::*;
	import alu_op_pkg::*;

	half_t a_lo;
	half_t b_lo;
	half_t w_res;
	logic [5:0] shamt;
	logic [4:0] shamt_w; // word shifts only see 5 bits

	function automatic word_t sext_half(half_t h);
		return {{hlen{h[hlen-1]}}, h};
	endfunction

	function automatic word_t flag(logic f);
		return {{(xlen-1){1'b0}}, f};
	endfunction

	assign a_lo = src_a[hlen-1:0];
	assign b_lo = src_b[hlen-1:0];
	assign shamt = src_b[5:0];
	assign shamt_w = src_b[4:0];

	// 32-bit half of the word variants
	always_comb begin
		case (op)
			op_addw: w_res = a_lo + b_lo;
			op_sllw: w_res = a_lo << shamt_w;
			op_sraw: w_res = $signed(a_lo) >>> shamt_w;
			op_srlw: w_res = a_lo >> shamt_w;
			op_subw: w_res = a_lo - b_lo;
			default: w_res = '0;
		endcase
	end

	always_comb begin
		case (op)
			op_add:  alu_result = src_a + src_b;
			op_sll:  alu_result = src_a << shamt;
			op_sra:  alu_result = $signed(src_a) >>> shamt;
			op_srl:  alu_result = src_a >> shamt;
			op_and:  alu_result = src_a & src_b;
			op_or:   alu_result = src_a | src_b;
			op_xor:  alu_result = src_a ^ src_b;
			op_slt:  alu_result = flag($signed(src_a) < $signed(src_b));
			op_sltu: alu_result = flag(src_a < src_b);
			op_eq:   alu_result = flag(src_a == src_b);
			op_ne:   alu_result = flag(src_a != src_b);
			op_ge:   alu_result = flag($signed(src_a) >= $signed(src_b));
			op_geu:  alu_result = flag(src_a >= src_b);
			op_sub:  alu_result = src_a - src_b;
			op_addw,
			op_sllw,
			op_sraw,
			op_srlw,
			op_subw: alu_result = sext_half(w_res);
			default: alu_result = '0; // divide class and unused codes
		endcase
	end

endmodule

// File: div_if.sv
interface div_if;

	logic load; // one cycle, operands captured
	logic step; // one iteration per cycle
	logic is_word;
	logic is_signed;
	logic want_rem;
	logic last; // final iteration

	modport ctrl (
		output load,
		output step,
		output is_word,
		output is_signed,
		output want_rem,
		input  last
	);

	modport counter (
		input  load,
		input  step,
		input  is_word,
		output last
	);

	modport datapath (
		input load,
		input step,
		input is_word,
		input is_signed,
		input want_rem
	);

endinterface

// File: alu_op_pkg.sv
package alu_op_pkg;

	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_ge    = 5'd15,
		op_geu   = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_div   = 5'd23, // 19..22 unused here
		op_divu  = 5'd24,
		op_divw  = 5'd25,
		op_divuw = 5'd26,
		op_rem   = 5'd27,
		op_remu  = 5'd28,
		op_remuw = 5'd29,
		op_remw  = 5'd30
	} alu_op_e;

	localparam alu_op_e div_first = op_div;
	localparam alu_op_e div_last = op_remw;

	function automatic logic op_is_div(alu_op_e op);
		return (op >= div_first) && (op <= div_last);
	endfunction

endpackage

// File: ex_types_pkg.sv
package ex_types_pkg;

	localparam int xlen = 64; // rv64 data width
	localparam int hlen = xlen / 2; // low half for the word ops

	typedef logic [xlen-1:0] word_t;
	typedef logic [hlen-1:0] half_t;

	typedef logic [4:0] reg_addr_t;

	// branch offset, bit 0 is implied zero
	typedef logic [12:1] b_imm_t;

endpackage
